//--- verilog/decode_macros.svh
// widths of the decoder buses
// bit positions in the status register
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// instruction register and status register
`define DR_DATA_W 8

// timing step counter
`define DR_TCU_W 4

// status register bits
`define DR_P_C 0
`define DR_P_Z 1
`define DR_P_V 6
`define DR_P_N 7

`endif

//--- verilog/decode_pkg.sv
// opcode, group, register, ALU and timing step enums
// decoded operation record and control line structs
`default_nettype none
`include "decode_macros.svh"

package decode_pkg;

    typedef enum logic [`DR_DATA_W-1:0] {
        op_nop   = 8'hea, op_inx   = 8'he8, op_iny   = 8'hc8, op_dex   = 8'hca,
        op_dey   = 8'h88, op_lda_i = 8'ha9, op_ldx_i = 8'ha2, op_ldy_i = 8'ha0,
        op_tax   = 8'haa, op_tay   = 8'ha8, op_tsx   = 8'hba, op_txa   = 8'h8a,
        op_txs   = 8'h9a, op_tya   = 8'h98, op_lsr_a = 8'h4a, op_asl_a = 8'h0a,
        op_rol_a = 8'h2a, op_ror_a = 8'h6a, op_clc   = 8'h18, op_sec   = 8'h38,
        op_cli   = 8'h58, op_sei   = 8'h78, op_clv   = 8'hb8, op_pha   = 8'h48,
        op_php   = 8'h08, op_pla   = 8'h68, op_plp   = 8'h28, op_and_i = 8'h29,
        op_eor_i = 8'h49, op_ora_i = 8'h09, op_adc_i = 8'h69, op_sbc_i = 8'he9,
        op_cmp_i = 8'hc9, op_cpx_i = 8'he0, op_cpy_i = 8'hc0, op_bcc   = 8'h90,
        op_bcs   = 8'hb0, op_beq   = 8'hf0, op_bne   = 8'hd0, op_bmi   = 8'h30,
        op_bpl   = 8'h10, op_bvc   = 8'h50, op_bvs   = 8'h70
    } opcode_e;

    typedef enum logic [3:0] {
        grp_incdec, grp_shift, grp_flag, grp_load_imm, grp_alu_imm, grp_transfer,
        grp_nop, grp_push, grp_pull, grp_branch, grp_unknown
    } op_group_e;

    typedef enum logic [2:0] {reg_none, reg_ac, reg_x, reg_y, reg_s} reg_sel_e;

    typedef enum logic [2:0] {
        alu_none, alu_sum, alu_and, alu_eor, alu_or, alu_shift_right
    } alu_op_e;

    typedef enum logic [1:0] {cin_zero, cin_one, cin_p_carry, cin_not_p_carry} cin_sel_e;

    typedef enum logic [`DR_TCU_W-1:0] {
        step_t0, step_t1, step_t2, step_t3, step_t4, step_t5, step_t6, step_t7
    } tstep_e;

    typedef struct packed {
        opcode_e   opcode;
        op_group_e group;
        reg_sel_e  src;
        reg_sel_e  dst;
        alu_op_e   alu;
        cin_sel_e  cin;
    } op_info_t;

    // rw is high for a read
    typedef struct packed {
        logic rw;
        logic pcl_pcl, pch_pch, pcl_adl, pch_adh;
        logic adl_abl, adh_abh, i_pc, s_adl;
        logic add_adl, adl_pcl, adh_pch, sb_adh;
        logic zero_adh1_7;
    } addr_ctrl_t;

    typedef struct packed {
        logic dl_db, x_sb, y_sb, ac_sb, s_sb, ac_db, p_db, pch_db;
        logic add_sb, sb_db, sb_x, sb_y, sb_ac, sb_s;
        // ALU inputs and operation
        logic db_add, db_n_add, adl_add, sb_add, zero_add, one_addc;
        logic sums, ands, eors, ors, srs;
    } data_ctrl_t;

    typedef struct packed {
        logic dbz_z, db0_c, db1_z, db2_i, db3_d, db4_b, db6_v, db7_n;
        logic acr_c, ir5_c, ir5_i, avr_v;
    } flag_ctrl_t;

endpackage

`default_nettype wire

//--- verilog/opcode_classifier.sv
// instruction register to decoded operation record
// group, source and destination register, ALU operation, carry-in
`timescale 1ns/1ps
`default_nettype none
`include "decode_macros.svh"

module opcode_classifier
(
    input  wire logic [`DR_DATA_W-1:0] i_ir,
    output decode_pkg::op_info_t       o_op
);
    import decode_pkg::*;

    opcode_e code;

    function automatic op_info_t rec(op_group_e grp, reg_sel_e src, reg_sel_e dst,
                                     alu_op_e alu, cin_sel_e cin);
        op_info_t r;
        r.opcode = op_nop;
        r.group = grp;
        r.src = src;
        r.dst = dst;
        r.alu = alu;
        r.cin = cin;
        return r;
    endfunction

    assign code = opcode_e'(i_ir);

    always_comb
    begin
        case (code)
            // inc adds one via inverted zero, dec adds the precharged 0xff
            op_inx: o_op = rec(grp_incdec, reg_x, reg_x, alu_sum, cin_one);
            op_iny: o_op = rec(grp_incdec, reg_y, reg_y, alu_sum, cin_one);
            op_dex: o_op = rec(grp_incdec, reg_x, reg_x, alu_sum, cin_zero);
            op_dey: o_op = rec(grp_incdec, reg_y, reg_y, alu_sum, cin_zero);
            // left shifts are A + A
            op_asl_a: o_op = rec(grp_shift, reg_ac, reg_ac, alu_sum, cin_zero);
            op_rol_a: o_op = rec(grp_shift, reg_ac, reg_ac, alu_sum, cin_p_carry);
            op_lsr_a: o_op = rec(grp_shift, reg_ac, reg_ac, alu_shift_right, cin_zero);
            op_ror_a: o_op = rec(grp_shift, reg_ac, reg_ac, alu_shift_right, cin_p_carry);
            op_clc, op_sec, op_cli, op_sei, op_clv:
                o_op = rec(grp_flag, reg_none, reg_none, alu_none, cin_zero);
            op_lda_i: o_op = rec(grp_load_imm, reg_none, reg_ac, alu_none, cin_zero);
            op_ldx_i: o_op = rec(grp_load_imm, reg_none, reg_x, alu_none, cin_zero);
            op_ldy_i: o_op = rec(grp_load_imm, reg_none, reg_y, alu_none, cin_zero);
            op_and_i: o_op = rec(grp_alu_imm, reg_ac, reg_ac, alu_and, cin_zero);
            op_eor_i: o_op = rec(grp_alu_imm, reg_ac, reg_ac, alu_eor, cin_zero);
            op_ora_i: o_op = rec(grp_alu_imm, reg_ac, reg_ac, alu_or, cin_zero);
            op_adc_i: o_op = rec(grp_alu_imm, reg_ac, reg_ac, alu_sum, cin_p_carry);
            op_sbc_i: o_op = rec(grp_alu_imm, reg_ac, reg_ac, alu_sum, cin_not_p_carry);
            // compares keep only the flags
            op_cmp_i: o_op = rec(grp_alu_imm, reg_ac, reg_none, alu_sum, cin_one);
            op_cpx_i: o_op = rec(grp_alu_imm, reg_x, reg_none, alu_sum, cin_one);
            op_cpy_i: o_op = rec(grp_alu_imm, reg_y, reg_none, alu_sum, cin_one);
            op_tax: o_op = rec(grp_transfer, reg_ac, reg_x, alu_none, cin_zero);
            op_tay: o_op = rec(grp_transfer, reg_ac, reg_y, alu_none, cin_zero);
            op_tsx: o_op = rec(grp_transfer, reg_s, reg_x, alu_none, cin_zero);
            op_txa: o_op = rec(grp_transfer, reg_x, reg_ac, alu_none, cin_zero);
            op_txs: o_op = rec(grp_transfer, reg_x, reg_s, alu_none, cin_zero);
            op_tya: o_op = rec(grp_transfer, reg_y, reg_ac, alu_none, cin_zero);
            op_nop: o_op = rec(grp_nop, reg_none, reg_none, alu_none, cin_zero);
            // push source none means P
            op_pha: o_op = rec(grp_push, reg_ac, reg_none, alu_sum, cin_zero);
            op_php: o_op = rec(grp_push, reg_none, reg_none, alu_sum, cin_zero);
            op_pla: o_op = rec(grp_pull, reg_s, reg_ac, alu_sum, cin_one);
            op_plp: o_op = rec(grp_pull, reg_s, reg_none, alu_sum, cin_one);
            op_bcc, op_bcs, op_beq, op_bne, op_bmi, op_bpl, op_bvc, op_bvs:
                o_op = rec(grp_branch, reg_none, reg_none, alu_sum, cin_one);
            default: o_op = rec(grp_unknown, reg_none, reg_none, alu_none, cin_zero);
        endcase
        o_op.opcode = code;
    end

endmodule

`default_nettype wire

//--- verilog/step_sequencer.sv
// branch condition and remembered ALU carry
// next timing step
`timescale 1ns/1ps
`default_nettype none
`include "decode_macros.svh"

module step_sequencer
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic [`DR_TCU_W-1:0]  i_tcu,
    input  wire logic [`DR_DATA_W-1:0] i_p,
    input  wire logic                  i_acr,
    input  wire decode_pkg::op_info_t  i_op,
    output logic                       o_taken,
    output logic                       o_last_carry,
    output logic [`DR_TCU_W-1:0]       o_tcu
);
    import decode_pkg::*;

    tstep_e step;
    tstep_e next;
    logic   single;

    // carry out of the ALU from the previous cycle
    always_ff @(negedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_last_carry <= 1'b0;
        else
            o_last_carry <= i_acr;
    end

    always_comb
    begin
        case (i_op.opcode)
            op_bcc: o_taken = !i_p[`DR_P_C];
            op_bcs: o_taken = i_p[`DR_P_C];
            op_beq: o_taken = i_p[`DR_P_Z];
            op_bne: o_taken = !i_p[`DR_P_Z];
            op_bmi: o_taken = i_p[`DR_P_N];
            op_bpl: o_taken = !i_p[`DR_P_N];
            op_bvc: o_taken = !i_p[`DR_P_V];
            op_bvs: o_taken = i_p[`DR_P_V];
            default: o_taken = 1'b0;
        endcase
    end

    assign step = tstep_e'(i_tcu);
    assign single = i_op.group inside {grp_flag, grp_incdec, grp_shift, grp_load_imm,
                                       grp_alu_imm, grp_transfer, grp_nop};

    always_comb
    begin
        next = tstep_e'(i_tcu + `DR_TCU_W'(1));
        case (step)
            step_t0: next = step_t1;
            step_t1: if (single || (i_op.group == grp_branch && !o_taken)) next = step_t0;
            step_t2: if (i_op.group == grp_push) next = step_t0;
                     else if (i_op.group == grp_branch && !o_last_carry) next = step_t0;
            step_t3: if (i_op.group inside {grp_pull, grp_branch}) next = step_t0;
            default: next = tstep_e'(i_tcu + `DR_TCU_W'(1));
        endcase
    end

    assign o_tcu = next;

endmodule

`default_nettype wire

//--- verilog/address_control.sv
// program counter and address bus control lines
// PC fetch, stack addressing and branch target
`timescale 1ns/1ps
`default_nettype none
`include "decode_macros.svh"

module address_control
(
    input  wire logic [`DR_TCU_W-1:0] i_tcu,
    input  wire decode_pkg::op_info_t i_op,
    input  wire logic                 i_taken,
    output decode_pkg::addr_ctrl_t    o_addr
);
    import decode_pkg::*;

    tstep_e step;
    logic   fetch;
    logic   stack;
    logic   known;

    assign step = tstep_e'(i_tcu);
    assign known = (i_op.group != grp_unknown);

    always_comb
    begin
        o_addr = '0;
        o_addr.rw = 1'b1;
        fetch = 1'b0;
        stack = 1'b0;
        case (step)
            step_t0:
            begin
                fetch = known;
                o_addr.i_pc = known;
            end
            step_t1:
            begin
                fetch = known;
                o_addr.i_pc = (i_op.group inside {grp_load_imm, grp_alu_imm})
                              || (i_op.group == grp_branch && !i_taken);
            end
            step_t2:
            begin
                if (i_op.group inside {grp_push, grp_pull})
                begin
                    stack = 1'b1;
                    o_addr.s_adl = 1'b1;
                    o_addr.rw = (i_op.group != grp_push);
                end
                else if (i_op.group == grp_branch)
                begin
                    // new PCL from the ALU, PCH kept
                    o_addr.pch_adh = 1'b1;
                    o_addr.adh_abh = 1'b1;
                    o_addr.add_adl = 1'b1;
                    o_addr.adl_abl = 1'b1;
                    o_addr.adl_pcl = 1'b1;
                    o_addr.pch_pch = 1'b1;
                end
            end
            step_t3:
            begin
                if (i_op.group == grp_pull)
                begin
                    stack = 1'b1;
                    o_addr.add_adl = 1'b1;
                end
                else if (i_op.group == grp_branch)
                begin
                    // corrected PCH from the ALU via SB
                    o_addr.sb_adh = 1'b1;
                    o_addr.adh_abh = 1'b1;
                    o_addr.adh_pch = 1'b1;
                    o_addr.pcl_adl = 1'b1;
                    o_addr.adl_abl = 1'b1;
                    o_addr.pcl_pcl = 1'b1;
                end
            end
            default: stack = 1'b0;
        endcase

        if (fetch)
        begin
            o_addr.pcl_adl = 1'b1;
            o_addr.adl_abl = 1'b1;
            o_addr.pch_adh = 1'b1;
            o_addr.adh_abh = 1'b1;
            o_addr.pcl_pcl = 1'b1;
            o_addr.pch_pch = 1'b1;
        end
        // stack lives on page one
        if (stack)
        begin
            o_addr.adl_abl = 1'b1;
            o_addr.zero_adh1_7 = 1'b1;
            o_addr.adh_abh = 1'b1;
            o_addr.pcl_pcl = 1'b1;
            o_addr.pch_pch = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/datapath_control.sv
// register, internal bus and ALU control lines
`timescale 1ns/1ps
`default_nettype none
`include "decode_macros.svh"

module datapath_control
(
    input  wire logic [`DR_TCU_W-1:0]  i_tcu,
    input  wire decode_pkg::op_info_t  i_op,
    input  wire logic [`DR_DATA_W-1:0] i_p,
    input  wire logic                  i_taken,
    input  wire logic                  i_last_carry,
    output decode_pkg::data_ctrl_t     o_data
);
    import decode_pkg::*;

    tstep_e step;
    logic   cin;
    logic   inv_b;
    logic   rd_src;
    logic   wr_dst;
    logic   use_alu;

    assign step = tstep_e'(i_tcu);

    always_comb
    begin
        case (i_op.cin)
            cin_one: cin = 1'b1;
            cin_p_carry: cin = i_p[`DR_P_C];
            cin_not_p_carry: cin = !i_p[`DR_P_C];
            default: cin = 1'b0;
        endcase
    end

    // subtraction style sums take the inverted DB
    assign inv_b = (i_op.alu == alu_sum) && (i_op.cin inside {cin_one, cin_not_p_carry});

    always_comb
    begin
        o_data = '0;
        rd_src = 1'b0;
        wr_dst = 1'b0;
        use_alu = 1'b0;
        case (step)
            step_t0:
            begin
                // finish the previous opcode
                if (i_op.group inside {grp_incdec, grp_shift, grp_alu_imm})
                begin
                    o_data.add_sb = 1'b1;
                    o_data.sb_db = 1'b1;
                    wr_dst = 1'b1;
                end
                else if (i_op.group == grp_push)
                begin
                    o_data.add_sb = 1'b1;
                    o_data.sb_s = 1'b1;
                end
            end
            step_t1:
            begin
                case (i_op.group)
                    grp_incdec, grp_alu_imm:
                    begin
                        rd_src = 1'b1;
                        use_alu = 1'b1;
                        o_data.sb_add = 1'b1;
                        o_data.dl_db = (i_op.group == grp_alu_imm);
                        o_data.db_n_add = inv_b;
                        o_data.db_add = !inv_b;
                    end
                    grp_shift:
                    begin
                        rd_src = 1'b1;
                        use_alu = 1'b1;
                        o_data.sb_add = 1'b1;
                        // AC on both ALU inputs for a left shift
                        o_data.sb_db = (i_op.alu == alu_sum);
                        o_data.db_add = (i_op.alu == alu_sum);
                    end
                    grp_load_imm:
                    begin
                        wr_dst = 1'b1;
                        o_data.dl_db = 1'b1;
                        o_data.sb_db = 1'b1;
                    end
                    grp_transfer:
                    begin
                        rd_src = 1'b1;
                        wr_dst = 1'b1;
                        o_data.sb_db = (i_op.dst != reg_s);
                    end
                    grp_pull:
                    begin
                        // S + 1
                        rd_src = 1'b1;
                        use_alu = 1'b1;
                        o_data.sb_add = 1'b1;
                        o_data.db_n_add = 1'b1;
                    end
                    grp_branch:
                    begin
                        // PCL + 1 + offset
                        use_alu = i_taken;
                        o_data.adl_add = i_taken;
                        o_data.dl_db = i_taken;
                        o_data.sb_db = i_taken;
                        o_data.sb_add = i_taken;
                    end
                    default: rd_src = 1'b0;
                endcase
            end
            step_t2:
            begin
                if (i_op.group == grp_branch && i_last_carry)
                begin
                    // PCH + 1 on a page crossing
                    use_alu = 1'b1;
                    o_data.pch_db = 1'b1;
                    o_data.db_add = 1'b1;
                    o_data.zero_add = 1'b1;
                end
                else if (i_op.group == grp_push)
                begin
                    // S - 1 with SB precharged to 0xff
                    use_alu = 1'b1;
                    o_data.adl_add = 1'b1;
                    o_data.sb_add = 1'b1;
                    o_data.ac_db = (i_op.src == reg_ac);
                    o_data.p_db = (i_op.src == reg_none);
                end
                else if (i_op.group == grp_pull)
                begin
                    o_data.add_sb = 1'b1;
                    o_data.sb_s = 1'b1;
                    o_data.sb_add = 1'b1;
                    o_data.db_n_add = 1'b1;
                    o_data.sums = 1'b1;
                end
            end
            step_t3:
            begin
                o_data.add_sb = (i_op.group == grp_branch);
                if (i_op.group == grp_pull)
                begin
                    o_data.dl_db = 1'b1;
                    o_data.sb_db = (i_op.dst != reg_none);
                    wr_dst = 1'b1;
                end
            end
            default: use_alu = 1'b0;
        endcase

        if (rd_src)
        begin
            o_data.ac_sb = (i_op.src == reg_ac);
            o_data.x_sb = (i_op.src == reg_x);
            o_data.y_sb = (i_op.src == reg_y);
            o_data.s_sb = (i_op.src == reg_s);
        end
        if (wr_dst)
        begin
            o_data.sb_ac = (i_op.dst == reg_ac);
            o_data.sb_x = (i_op.dst == reg_x);
            o_data.sb_y = (i_op.dst == reg_y);
            o_data.sb_s = (i_op.dst == reg_s);
        end
        if (use_alu)
        begin
            o_data.sums = (i_op.alu == alu_sum);
            o_data.ands = (i_op.alu == alu_and);
            o_data.eors = (i_op.alu == alu_eor);
            o_data.ors = (i_op.alu == alu_or);
            o_data.srs = (i_op.alu == alu_shift_right);
            o_data.one_addc = cin;
        end
    end

endmodule

`default_nettype wire

//--- verilog/flag_control.sv
// status register load lines
`timescale 1ns/1ps
`default_nettype none
`include "decode_macros.svh"

module flag_control
(
    input  wire logic [`DR_TCU_W-1:0] i_tcu,
    input  wire decode_pkg::op_info_t i_op,
    output decode_pkg::flag_ctrl_t    o_flags
);
    import decode_pkg::*;

    tstep_e step;
    logic   zn_t0;
    logic   zn_t1;
    logic   arith;

    assign step = tstep_e'(i_tcu);
    assign zn_t0 = i_op.group inside {grp_incdec, grp_shift, grp_alu_imm};
    assign zn_t1 = (i_op.group == grp_load_imm)
                   || (i_op.group == grp_transfer && i_op.opcode != op_txs);
    assign arith = (i_op.group == grp_alu_imm) && (i_op.alu == alu_sum);

    always_comb
    begin
        o_flags = '0;
        o_flags.dbz_z = (step == step_t0 && zn_t0) || (step == step_t1 && zn_t1);
        o_flags.db7_n = o_flags.dbz_z;
        if (step == step_t1)
        begin
            o_flags.acr_c = arith || (i_op.group == grp_shift);
            o_flags.avr_v = arith || (i_op.opcode == op_clv);
            // IR bit 5 holds the new value
            o_flags.ir5_c = i_op.opcode inside {op_clc, op_sec};
            o_flags.ir5_i = i_op.opcode inside {op_cli, op_sei};
        end
        // PLP takes the whole status byte from DB
        if (step == step_t3 && i_op.opcode == op_plp)
        begin
            o_flags.db0_c = 1'b1;
            o_flags.db1_z = 1'b1;
            o_flags.db2_i = 1'b1;
            o_flags.db3_d = 1'b1;
            o_flags.db4_b = 1'b1;
            o_flags.db6_v = 1'b1;
            o_flags.db7_n = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/decode_rom.sv
// decode ROM top level
// classifier, step sequencer and the three control blocks
`timescale 1ns/1ps
`default_nettype none
`include "decode_macros.svh"

module decode_rom
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic [`DR_DATA_W-1:0] i_ir,
    input  wire logic [`DR_TCU_W-1:0]  i_tcu,
    input  wire logic [`DR_DATA_W-1:0] i_p,
    input  wire logic                  i_acr,
    output logic [`DR_TCU_W-1:0]       o_tcu,
    output decode_pkg::addr_ctrl_t     o_addr,
    output decode_pkg::data_ctrl_t     o_data,
    output decode_pkg::flag_ctrl_t     o_flags
);
    import decode_pkg::*;

    op_info_t op;
    logic     taken;
    logic     last_carry;

    opcode_classifier u_classifier (.i_ir(i_ir), .o_op(op));

    step_sequencer u_sequencer (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_tcu(i_tcu), .i_p(i_p), .i_acr(i_acr),
        .i_op(op), .o_taken(taken), .o_last_carry(last_carry), .o_tcu(o_tcu)
    );

    address_control u_addr (.i_tcu(i_tcu), .i_op(op), .i_taken(taken), .o_addr(o_addr));

    datapath_control u_data (
        .i_tcu(i_tcu), .i_op(op), .i_p(i_p), .i_taken(taken),
        .i_last_carry(last_carry), .o_data(o_data)
    );

    flag_control u_flags (.i_tcu(i_tcu), .i_op(op), .o_flags(o_flags));

endmodule

`default_nettype wire

//--- verif/tb_decode_ref.svh
// expected decoder response for the testbench
// opcode groups, branch condition, next step, result and ALU lines
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

localparam int kind_incdec = 0;
localparam int kind_shift = 1;
localparam int kind_flag = 2;
localparam int kind_load_imm = 3;
localparam int kind_alu_imm = 4;
localparam int kind_transfer = 5;
localparam int kind_nop = 6;
localparam int kind_push = 7;
localparam int kind_pull = 8;
localparam int kind_branch = 9;
localparam int kind_unknown = 10;

function automatic int group_of(input logic [7:0] ir);
    case (ir)
        8'he8, 8'hc8, 8'hca, 8'h88: return kind_incdec;
        8'h0a, 8'h2a, 8'h4a, 8'h6a: return kind_shift;
        8'h18, 8'h38, 8'h58, 8'h78, 8'hb8: return kind_flag;
        8'ha9, 8'ha2, 8'ha0: return kind_load_imm;
        8'h29, 8'h49, 8'h09, 8'h69, 8'he9, 8'hc9, 8'he0, 8'hc0: return kind_alu_imm;
        8'haa, 8'ha8, 8'hba, 8'h8a, 8'h9a, 8'h98: return kind_transfer;
        8'hea: return kind_nop;
        8'h48, 8'h08: return kind_push;
        8'h68, 8'h28: return kind_pull;
        8'h90, 8'hb0, 8'hf0, 8'hd0, 8'h30, 8'h10, 8'h50, 8'h70: return kind_branch;
        default: return kind_unknown;
    endcase
endfunction

// bits 7:6 pick the flag, bit 5 is the value that takes the branch
function automatic logic cond_met(input logic [7:0] ir, input logic [7:0] p);
    logic flag;
    case (ir[7:6])
        2'b00: flag = p[`DR_P_N];
        2'b01: flag = p[`DR_P_V];
        2'b10: flag = p[`DR_P_C];
        default: flag = p[`DR_P_Z];
    endcase
    return flag == ir[5];
endfunction

function automatic logic [3:0] next_step(input logic [7:0] ir, input logic [3:0] tcu,
                                         input logic [7:0] p, input logic carry);
    int   grp;
    logic single;
    grp = group_of(ir);
    single = grp inside {kind_flag, kind_incdec, kind_shift, kind_load_imm,
                         kind_alu_imm, kind_transfer, kind_nop};
    if (grp == kind_unknown)
        return tcu + 4'd1;
    if (tcu == 4'd0)
        return 4'd1;
    if (tcu == 4'd1 && (single || (grp == kind_branch && !cond_met(ir, p))))
        return 4'd0;
    // taken branch stops at T2 unless the page was crossed
    if (tcu == 4'd2 && (grp == kind_push || (grp == kind_branch && !carry)))
        return 4'd0;
    if (tcu == 4'd3 && (grp == kind_pull || grp == kind_branch))
        return 4'd0;
    return tcu + 4'd1;
endfunction

// {sb_ac, sb_x, sb_y, sb_s} when a T0 result is written back
function automatic logic [3:0] dest_lines(input logic [7:0] ir);
    case (ir)
        8'he8, 8'hca: return 4'b0100;
        8'hc8, 8'h88: return 4'b0010;
        8'hc9, 8'he0, 8'hc0: return 4'b0000;
        default: return 4'b1000;
    endcase
endfunction

// {sums, ands, eors, ors, srs}
function automatic logic [4:0] alu_line_for(input logic [7:0] ir);
    case (ir)
        8'h29: return 5'b01000;
        8'h49: return 5'b00100;
        8'h09: return 5'b00010;
        8'h4a, 8'h6a: return 5'b00001;
        default: return 5'b10000;
    endcase
endfunction

function automatic logic carry_in_for(input logic [7:0] ir, input logic [7:0] p);
    case (ir)
        8'h69: return p[`DR_P_C];
        8'he9: return !p[`DR_P_C];
        default: return 1'b1;
    endcase
endfunction

`endif

//--- verif/tb_decode_rom.sv
// testbench for the decode ROM
// opcode walks, unknown opcode sweep, per cycle compare and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "decode_macros.svh"

module tb_decode_rom;
    import decode_pkg::*;

    localparam int clk_period = 10;
    localparam int reset_cycles = 3;
    localparam int num_kept = 43;
    localparam int walk_reps = 4;
    // at most four steps per walk, plus the full byte sweep
    localparam int max_vectors = num_kept * walk_reps * 4 + 256 + reset_cycles + 4;

    `include "tb_decode_ref.svh"

    logic                  i_clk;
    logic                  i_rst_n;
    logic [`DR_DATA_W-1:0] i_ir;
    logic [`DR_TCU_W-1:0]  i_tcu;
    logic [`DR_DATA_W-1:0] i_p;
    logic                  i_acr;
    logic [`DR_TCU_W-1:0]  o_tcu;
    addr_ctrl_t            o_addr;
    data_ctrl_t            o_data;
    flag_ctrl_t            o_flags;

    logic   armed;
    int     errors;
    integer seed;

    logic [7:0] kept_ops [num_kept] = '{
        8'he8, 8'hc8, 8'hca, 8'h88, 8'h0a, 8'h2a, 8'h4a, 8'h6a, 8'h18, 8'h38, 8'h58,
        8'h78, 8'hb8, 8'ha9, 8'ha2, 8'ha0, 8'h29, 8'h49, 8'h09, 8'h69, 8'he9, 8'hc9,
        8'he0, 8'hc0, 8'haa, 8'ha8, 8'hba, 8'h8a, 8'h9a, 8'h98, 8'hea, 8'h48, 8'h08,
        8'h68, 8'h28, 8'h90, 8'hb0, 8'hf0, 8'hd0, 8'h30, 8'h10, 8'h50, 8'h70
    };

    decode_rom u_dut (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_ir(i_ir), .i_tcu(i_tcu), .i_p(i_p),
        .i_acr(i_acr), .o_tcu(o_tcu), .o_addr(o_addr), .o_data(o_data), .o_flags(o_flags)
    );

    always #(clk_period / 2) i_clk = ~i_clk;

    task automatic compare_field(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", what, expected, actual);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic verify_vector();
        int         grp;
        string      name;
        addr_ctrl_t idle_addr;
        logic [6:0] fetch_bits;
        logic [3:0] finish_bits;
        logic [3:0] dest_bits;
        logic [4:0] alu_bits;
        logic [2:0] stack_bits;
        logic [7:0] plp_bits;
        grp = group_of(i_ir);
        name = $sformatf("op %h T%0d", i_ir, i_tcu);
        idle_addr = '0;
        idle_addr.rw = 1'b1;
        fetch_bits = {o_addr.pcl_adl, o_addr.adl_abl, o_addr.pch_adh, o_addr.adh_abh,
                      o_addr.pcl_pcl, o_addr.pch_pch, o_addr.i_pc};
        finish_bits = {o_data.add_sb, o_data.sb_db, o_flags.dbz_z, o_flags.db7_n};
        dest_bits = {o_data.sb_ac, o_data.sb_x, o_data.sb_y, o_data.sb_s};
        alu_bits = {o_data.sums, o_data.ands, o_data.eors, o_data.ors, o_data.srs};
        stack_bits = {o_addr.rw, o_data.ac_db, o_data.p_db};
        // zero detect stays off while the bits come straight from DB
        plp_bits = {o_flags.dbz_z, o_flags.db0_c, o_flags.db1_z, o_flags.db2_i,
                    o_flags.db3_d, o_flags.db4_b, o_flags.db6_v, o_flags.db7_n};

        // i_acr is held through a whole walk, so it is also the remembered carry
        compare_field({name, " next step"}, 32'(next_step(i_ir, i_tcu, i_p, i_acr)),
                      32'(o_tcu));
        if (grp == kind_unknown)
        begin
            compare_field({name, " address lines"}, 32'(idle_addr), 32'(o_addr));
            compare_field({name, " datapath lines"}, 32'd0, 32'(o_data));
            compare_field({name, " flag lines"}, 32'd0, 32'(o_flags));
        end
        else if (i_tcu == 4'd0)
        begin
            compare_field({name, " fetch lines"}, 32'h7f, 32'(fetch_bits));
            if (grp == kind_incdec || grp == kind_shift || grp == kind_alu_imm)
            begin
                compare_field({name, " result path"}, 32'hf, 32'(finish_bits));
                compare_field({name, " destination"}, 32'(dest_lines(i_ir)),
                              32'(dest_bits));
            end
        end
        else if (i_tcu == 4'd1)
        begin
            if (grp == kind_alu_imm)
            begin
                compare_field({name, " alu operation"}, 32'(alu_line_for(i_ir)),
                              32'(alu_bits));
                if (alu_line_for(i_ir) == 5'b10000)
                    compare_field({name, " carry in"}, 32'(carry_in_for(i_ir, i_p)),
                                  32'(o_data.one_addc));
            end
            // PC only steps on when the branch falls through
            if (grp == kind_branch)
                compare_field({name, " not taken"}, 32'(!cond_met(i_ir, i_p)),
                              32'(o_addr.i_pc));
        end
        else if (i_tcu == 4'd2 && grp == kind_push)
        begin
            compare_field({name, " push write"},
                          32'({1'b0, i_ir == 8'h48, i_ir == 8'h08}), 32'(stack_bits));
        end
        else if (i_tcu == 4'd3 && grp == kind_pull)
        begin
            if (i_ir == 8'h68)
                compare_field({name, " load ac"}, 32'd1, 32'(o_data.sb_ac));
            else
                compare_field({name, " status load"}, 32'h7f, 32'(plp_bits));
        end
    endtask

    task automatic apply_vector(input logic [7:0] ir, input logic [3:0] tcu,
                                input logic [7:0] p, input logic acr);
        @(posedge i_clk);
        i_ir <= ir;
        i_tcu <= tcu;
        i_p <= p;
        i_acr <= acr;
        armed <= 1'b1;
    endtask

    // from T0 until the reference step returns to T0
    task automatic walk_opcode(input logic [7:0] ir, input logic [7:0] p, input logic acr);
        logic [3:0] tcu;
        int         steps;
        tcu = 4'd0;
        steps = 0;
        do
        begin
            apply_vector(ir, tcu, p, acr);
            tcu = next_step(ir, tcu, p, acr);
            steps++;
        end
        while (tcu != 4'd0 && steps < 4);
    endtask

    function automatic logic [7:0] with_condition_met(input logic [7:0] ir,
                                                      input logic [7:0] p);
        logic [7:0] q;
        q = p;
        case (ir[7:6])
            2'b00: q[`DR_P_N] = ir[5];
            2'b01: q[`DR_P_V] = ir[5];
            2'b10: q[`DR_P_C] = ir[5];
            default: q[`DR_P_Z] = ir[5];
        endcase
        return q;
    endfunction

    always @(negedge i_clk)
    begin
        if (armed)
            verify_vector();
    end

    initial
    begin
        #(2 * max_vectors * clk_period);
        $display("timeout: stimulus did not finish within %0d vectors", max_vectors);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [7:0] p;
        logic       acr;
        seed = 86;
        errors = 0;
        i_clk = 1'b0;
        i_rst_n <= 1'b0;
        i_ir <= 8'hea;
        i_tcu <= 4'd0;
        i_p <= 8'h00;
        i_acr <= 1'b0;
        armed <= 1'b0;
        repeat (reset_cycles) @(posedge i_clk);
        i_rst_n <= 1'b1;

        foreach (kept_ops[k])
        begin
            for (int rep = 0; rep < walk_reps; rep++)
            begin
                p = 8'($random(seed));
                acr = 1'($random(seed));
                // first two branch walks are taken, once per carry value
                if (group_of(kept_ops[k]) == kind_branch && rep < 2)
                begin
                    p = with_condition_met(kept_ops[k], p);
                    acr = rep[0];
                end
                walk_opcode(kept_ops[k], p, acr);
            end
        end

        for (int b = 0; b < 256; b++)
        begin
            if (group_of(8'(b)) == kind_unknown)
                apply_vector(8'(b), 4'($random(seed)), 8'($random(seed)),
                             1'($random(seed)));
        end

        @(posedge i_clk);
        armed <= 1'b0;
        @(negedge i_clk);
        if (errors == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
+incdir+verif
verilog/decode_pkg.sv
verilog/opcode_classifier.sv
verilog/step_sequencer.sv
verilog/address_control.sv
verilog/datapath_control.sv
verilog/flag_control.sv
verilog/decode_rom.sv
verif/tb_decode_rom.sv

//--- run_sim.sh
#!/bin/sh
# build the decode ROM testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_decode_rom -o sim_decode_rom
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_decode_rom > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All tests passed$" "$log"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
